// File: flist.f
rtl/ulpb_node_pkg.sv
rtl/ulpb_bus_pkg.sv
rtl/ulpb_tx_queue.sv
rtl/ulpb_tx_framer.sv
rtl/ulpb_rx_framer.sv
rtl/ulpb_node_core.sv
rtl/ulpb_node_top.sv
tb/ulpb_ring_model.sv
tb/ulpb_node_tb.sv

// File: Makefile
TOP = ulpb_node_tb

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/100ps --top-module ulpb_node_top \
		$(shell grep '^rtl/' flist.f)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: tb/ulpb_node_tb.sv
module ulpb_node_tb
	import ulpb_node_pkg::*;
	import ulpb_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [ADDR_WIDTH-1:0] NODE_ADDR   = 8'hab;
	localparam int                    DEPTH       = 8;
	localparam int                    RING_DELAY  = 5;
	localparam int                    FRAME_COUNT = 16; // frames over all tests.
	localparam int                    CYCLE_LIMIT =
		FRAME_COUNT * (FRAME_BITS + RING_DELAY + 10) * 3;

	localparam ulpb_tx_result_t RES_SUCCESS = '{success: 1'b1, fail: 1'b0};
	localparam ulpb_tx_result_t RES_FAIL    = '{success: 1'b0, fail: 1'b1};
	localparam ulpb_tx_result_t RES_NONE    = '{success: 1'b0, fail: 1'b0};

	logic                  CLK;
	logic                  RESET;
	logic                  din;
	logic                  dout;
	ulpb_msg_t             lc_tx_msg;
	logic                  lc_tx_req;
	logic                  lc_tx_ack;
	ulpb_msg_t             lc_rx_msg;
	logic                  lc_rx_req;
	logic                  lc_rx_ack;
	ulpb_tx_result_t       tx_result;
	logic                  tx_ack;
	logic                  m_din;
	logic                  m_dout;
	ulpb_msg_t             m_rx_msg;
	logic                  m_rx_req;
	logic                  m_rx_ack;
	logic                  block;
	logic                  inject;
	logic                  m_inject;
	ulpb_msg_t             inject_msg;
	logic [ADDR_WIDTH-1:0] remote_addr;
	logic                  remote_ack_en;
	logic                  inj_busy;
	logic                  m_inj_busy;
	ulpb_msg_t             cap_msg;
	ulpb_msg_t             m_cap_msg;
	logic                  cap_ack;
	logic                  m_cap_ack;
	int                    cap_count;
	int                    seed = 15817;
	int                    errors = 0;
	int                    checks = 0;
	int                    cycles = 0;

	ulpb_node_top #(.ADDRESS(NODE_ADDR), .ADDRESS_MASK(8'hff), .QUEUE_DEPTH(DEPTH))
		ulpb_node_top_inst
	(
		.CLK(CLK), .RESET(RESET), .DIN(din), .DOUT(dout),
		.lc_tx_msg(lc_tx_msg), .lc_tx_req(lc_tx_req), .lc_tx_ack(lc_tx_ack),
		.lc_rx_msg(lc_rx_msg), .lc_rx_req(lc_rx_req), .lc_rx_ack(lc_rx_ack),
		.tx_result(tx_result), .tx_ack(tx_ack)
	);

	ulpb_ring_model ring_model_inst
	(
		.CLK(CLK), .RESET(RESET), .dout(dout), .din(din), .block(block),
		.inject(inject), .inject_msg(inject_msg), .remote_addr(remote_addr),
		.remote_ack_en(remote_ack_en), .inj_busy(inj_busy),
		.last_msg(cap_msg), .last_ack(cap_ack), .frame_count(cap_count)
	);

	// second node on its own ring ignores the low address nibble.
	ulpb_node_top #(.ADDRESS(NODE_ADDR), .ADDRESS_MASK(8'hf0), .QUEUE_DEPTH(DEPTH))
		ulpb_node_top_masked_inst
	(
		.CLK(CLK), .RESET(RESET), .DIN(m_din), .DOUT(m_dout),
		.lc_tx_msg('0), .lc_tx_req(1'b0), .lc_tx_ack(),
		.lc_rx_msg(m_rx_msg), .lc_rx_req(m_rx_req), .lc_rx_ack(m_rx_ack),
		.tx_result(), .tx_ack(1'b0)
	);

	ulpb_ring_model masked_ring_model_inst
	(
		.CLK(CLK), .RESET(RESET), .dout(m_dout), .din(m_din), .block(1'b0),
		.inject(m_inject), .inject_msg(inject_msg), .remote_addr(remote_addr),
		.remote_ack_en(remote_ack_en), .inj_busy(m_inj_busy),
		.last_msg(m_cap_msg), .last_ack(m_cap_ack), .frame_count()
	);

	always #20 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Error: simulation timed out waiting for a response (%0d cycles)", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// ********************
	// compare tasks
	// ********************

	task automatic check_msg(input ulpb_msg_t got, input ulpb_msg_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0d ns: %s got addr %h data %h, expected addr %h data %h",
				$time, what, got.addr, got.data, exp.addr, exp.data);
		end
	endtask

	task automatic check_result(input ulpb_tx_result_t got, input ulpb_tx_result_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0d ns: %s got success %b fail %b, expected success %b fail %b",
				$time, what, got.success, got.fail, exp.success, exp.fail);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0d ns: %s got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("Fail at %0d ns: %s got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// ********************
	// LC side helpers
	// ********************

	function automatic ulpb_msg_t make_msg(input logic [ADDR_WIDTH-1:0] addr);
		ulpb_msg_t msg;
		msg.addr = addr;
		msg.data = $random(seed);
		return msg;
	endfunction

	task automatic send_msg(input ulpb_msg_t msg);
		lc_tx_msg = msg;
		lc_tx_req = 1'b1;
		while (!lc_tx_ack)
			@(negedge CLK);
		lc_tx_req = 1'b0;
		while (lc_tx_ack)
			@(negedge CLK);
	endtask

	task automatic take_result(output ulpb_tx_result_t res);
		while (!(tx_result.success || tx_result.fail))
			@(negedge CLK);
		res    = tx_result;
		tx_ack = 1'b1;
		@(negedge CLK);
		tx_ack = 1'b0;
	endtask

	task automatic inject_frame(input ulpb_msg_t msg, input logic masked);
		inject_msg = msg;
		if (masked)
			m_inject = 1'b1;
		else
			inject = 1'b1;
		@(negedge CLK);
		inject   = 1'b0;
		m_inject = 1'b0;
		while (masked ? m_inj_busy : inj_busy) // until the frame is back.
			@(negedge CLK);
	endtask

	task automatic release_rx(input logic masked);
		if (masked)
			m_rx_ack = 1'b1;
		else
			lc_rx_ack = 1'b1;
		while (masked ? m_rx_req : lc_rx_req)
			@(negedge CLK);
		m_rx_ack  = 1'b0;
		lc_rx_ack = 1'b0;
	endtask

	task automatic report_test(input int num, input string name, input int err0);
		$display("test %0d %s finished with %0d errors", num, name, errors - err0);
	endtask

	// ********************
	// directed tests
	// ********************

	task automatic test_remote_ack();
		ulpb_msg_t       msg;
		ulpb_tx_result_t res;
		int              err0;
		err0          = errors;
		remote_addr   = 8'h3c;
		remote_ack_en = 1'b1;
		msg           = make_msg(8'h3c);
		send_msg(msg);
		take_result(res);
		check_result(res, RES_SUCCESS, "remote ack result");
		check_msg(cap_msg, msg, "serialized frame");
		report_test(1, "remote ack", err0);
	endtask

	task automatic test_no_ack();
		ulpb_tx_result_t res;
		int              err0;
		err0 = errors;
		send_msg(make_msg(8'h55));
		take_result(res);
		check_result(res, RES_FAIL, "unanswered result");
		report_test(2, "no ack", err0);
	endtask

	task automatic test_rx_match();
		ulpb_msg_t msg;
		int        err0;
		err0 = errors;
		msg  = make_msg(NODE_ADDR);
		inject_frame(msg, 1'b0);
		check_bit(lc_rx_req, 1'b1, "rx request on match");
		check_msg(lc_rx_msg, msg, "rx message");
		check_bit(cap_ack, ACK_TAKEN, "forwarded ack on match");
		release_rx(1'b0);
		msg = make_msg(8'h12);
		inject_frame(msg, 1'b0);
		check_bit(lc_rx_req, 1'b0, "rx request on mismatch");
		check_msg(cap_msg, msg, "forwarded frame");
		check_bit(cap_ack, ~ACK_TAKEN, "forwarded ack on mismatch");
		report_test(3, "rx match", err0);
	endtask

	task automatic test_rx_busy();
		ulpb_msg_t first;
		ulpb_msg_t second;
		int        err0;
		err0   = errors;
		first  = make_msg(NODE_ADDR);
		second = make_msg(NODE_ADDR);
		inject_frame(first, 1'b0);
		inject_frame(second, 1'b0);
		check_bit(cap_ack, ~ACK_TAKEN, "ack while LC output busy");
		check_bit(lc_rx_req, 1'b1, "rx request held");
		check_msg(lc_rx_msg, first, "rx message held");
		release_rx(1'b0);
		report_test(4, "rx busy", err0);
	endtask

	task automatic test_queue_full();
		ulpb_msg_t       msgs [DEPTH+1];
		ulpb_tx_result_t res;
		logic            early_ack;
		int              err0;
		int              frames0;
		err0          = errors;
		frames0       = cap_count;
		early_ack     = 1'b0;
		remote_addr   = 8'h3c;
		remote_ack_en = 1'b1;
		block         = 1'b1;
		repeat (2)
			@(negedge CLK);
		for (int i = 0; i <= DEPTH; i++)
			msgs[i] = make_msg(8'h3c);
		for (int i = 0; i < DEPTH; i++)
			send_msg(msgs[i]);
		lc_tx_msg = msgs[DEPTH];
		lc_tx_req = 1'b1;
		repeat (10)
		begin
			@(negedge CLK);
			if (lc_tx_ack)
				early_ack = 1'b1;
		end
		check_bit(early_ack, 1'b0, "accept while full");
		block = 1'b0;
		while (!lc_tx_ack)
			@(negedge CLK);
		check_bit(tx_result.success, 1'b1, "entry sent before last accept");
		lc_tx_req = 1'b0;
		while (lc_tx_ack)
			@(negedge CLK);
		for (int i = 0; i <= DEPTH; i++)
		begin
			take_result(res);
			check_result(res, RES_SUCCESS, "queued result");
			check_msg(cap_msg, msgs[i], "queued frame order");
		end
		repeat (2 * FRAME_BITS)
			@(negedge CLK);
		check_result(tx_result, RES_NONE, "no extra result");
		check_count(cap_count - frames0, DEPTH + 1, "frames sent for queued messages");
		report_test(5, "queue full", err0);
	endtask

	task automatic test_addr_mask();
		ulpb_msg_t msg;
		int        err0;
		err0 = errors;
		msg  = make_msg({NODE_ADDR[7:4], 4'h5});
		inject_frame(msg, 1'b1);
		check_bit(m_rx_req, 1'b1, "masked rx request");
		check_msg(m_rx_msg, msg, "masked rx message");
		check_msg(m_cap_msg, msg, "masked forwarded frame");
		check_bit(m_cap_ack, ACK_TAKEN, "masked forwarded ack");
		release_rx(1'b1);
		report_test(6, "address mask", err0);
	endtask

	initial
	begin
		CLK           = 1'b0;
		RESET         = 1'b0;
		lc_tx_msg     = '0;
		lc_tx_req     = 1'b0;
		lc_rx_ack     = 1'b0;
		tx_ack        = 1'b0;
		m_rx_ack      = 1'b0;
		block         = 1'b0;
		inject        = 1'b0;
		m_inject      = 1'b0;
		inject_msg    = '0;
		remote_addr   = '0;
		remote_ack_en = 1'b0;
		repeat (4)
			@(negedge CLK);
		RESET = 1'b1;
		repeat (2)
			@(negedge CLK);
		test_remote_ack();
		test_no_ack();
		test_rx_match();
		test_rx_busy();
		test_queue_full();
		test_addr_mask();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb/ulpb_ring_model.sv
module ulpb_ring_model
	import ulpb_node_pkg::*;
	import ulpb_bus_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RESET,
	input  logic                  dout,          // node output.
	output logic                  din,           // node input.
	input  logic                  block,         // holds the line low.
	input  logic                  inject,
	input  ulpb_msg_t             inject_msg,
	input  logic [ADDR_WIDTH-1:0] remote_addr,
	input  logic                  remote_ack_en,
	output logic                  inj_busy,
	output ulpb_msg_t             last_msg,
	output logic                  last_ack,
	output int                    frame_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [4:0]            pipe;       // fixed ring delay.
	int                    pos;        // 0 idle, then payload bits, then ack.
	logic [MSG_WIDTH-1:0]  sreg;
	logic                  returning;  // own injected frame coming back.
	logic                  inj_out;
	logic [FRAME_BITS-1:0] inj_sreg;
	int                    inj_cnt;
	logic                  block_d;
	logic                  gated;
	logic                  start_seen;
	logic                  ring_bit;

	assign din        = block ? START_LEVEL : pipe[4];
	assign inj_busy   = (inj_cnt > 0) || inj_out;
	assign gated      = block || block_d; // node output lags by one cycle.
	assign start_seen = (pos == 0) && (dout == START_LEVEL) && !gated;

	// ********************
	// remote node behavior
	// ********************

	always_comb
	begin
		if (gated)
			ring_bit = IDLE_LEVEL;
		else if (start_seen)
			ring_bit = inj_out ? IDLE_LEVEL : dout;
		else if (returning)
			ring_bit = IDLE_LEVEL; // injected frame ends here.
		else if (pos == FRAME_BITS - 1 && remote_ack_en &&
			sreg[MSG_WIDTH-1 -: ADDR_WIDTH] == remote_addr)
			ring_bit = ACK_TAKEN;
		else
			ring_bit = dout;
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			pipe        <= '1;
			pos         <= 0;
			sreg        <= '0;
			returning   <= 1'b0;
			inj_out     <= 1'b0;
			inj_sreg    <= '1;
			inj_cnt     <= 0;
			block_d     <= 1'b0;
			last_msg    <= '0;
			last_ack    <= 1'b0;
			frame_count <= 0;
		end
		else
		begin
			block_d <= block;
			pipe    <= {pipe[3:0], (inj_cnt > 0) ? inj_sreg[FRAME_BITS-1] : ring_bit};

			if (inject && !inj_busy)
			begin
				inj_sreg <= {START_LEVEL, inject_msg, ~ACK_TAKEN};
				inj_cnt  <= FRAME_BITS;
				inj_out  <= 1'b1;
			end
			else if (inj_cnt > 0)
			begin
				inj_sreg <= {inj_sreg[FRAME_BITS-2:0], IDLE_LEVEL};
				inj_cnt  <= inj_cnt - 1;
			end

			if (gated)
			begin
				pos       <= 0;
				returning <= 1'b0;
			end
			else if (start_seen)
			begin
				pos       <= 1;
				returning <= inj_out;
			end
			else if (pos > 0 && pos < FRAME_BITS - 1)
			begin
				pos  <= pos + 1;
				sreg <= {sreg[MSG_WIDTH-2:0], dout};
			end
			else if (pos == FRAME_BITS - 1)
			begin
				pos         <= 0;
				last_msg    <= sreg;
				last_ack    <= dout; // ack as the node sent it.
				frame_count <= frame_count + 1;
				returning   <= 1'b0;
				if (returning)
					inj_out <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/ulpb_node_top.sv
module ulpb_node_top
	import ulpb_node_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS      = 8'hab,
	parameter logic [ADDR_WIDTH-1:0] ADDRESS_MASK = 8'hff,
	parameter int                    QUEUE_DEPTH  = 8
)
(
	input  logic            CLK,
	input  logic            RESET,
	input  logic            DIN,
	output logic            DOUT,
	input  ulpb_msg_t       lc_tx_msg,
	input  logic            lc_tx_req,
	output logic            lc_tx_ack,
	output ulpb_msg_t       lc_rx_msg,
	output logic            lc_rx_req,
	input  logic            lc_rx_ack,
	output ulpb_tx_result_t tx_result,
	input  logic            tx_ack
);

	ulpb_msg_t head_msg;
	logic      q_empty;
	logic      pop;
	logic      tx_start;
	logic      tx_bit;
	logic      tx_busy;
	logic      sink;
	logic      fwd_bit;
	logic      in_frame;
	logic      ack_slot;
	logic      ack_value;

	ulpb_tx_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) ulpb_tx_queue_inst
	(
		.CLK(CLK), .RESET(RESET),
		.lc_tx_msg(lc_tx_msg), .lc_tx_req(lc_tx_req), .lc_tx_ack(lc_tx_ack),
		.pop(pop), .head_msg(head_msg), .q_empty(q_empty)
	);

	ulpb_tx_framer ulpb_tx_framer_inst
	(
		.CLK(CLK), .RESET(RESET),
		.tx_start(tx_start), .head_msg(head_msg),
		.tx_bit(tx_bit), .tx_busy(tx_busy)
	);

	ulpb_rx_framer #(.ADDRESS(ADDRESS), .ADDRESS_MASK(ADDRESS_MASK)) ulpb_rx_framer_inst
	(
		.CLK(CLK), .RESET(RESET),
		.DIN(DIN), .sink(sink), .fwd_bit(fwd_bit), .in_frame(in_frame),
		.ack_slot(ack_slot), .ack_value(ack_value),
		.lc_rx_msg(lc_rx_msg), .lc_rx_req(lc_rx_req), .lc_rx_ack(lc_rx_ack)
	);

	ulpb_node_core ulpb_node_core_inst
	(
		.CLK(CLK), .RESET(RESET),
		.q_empty(q_empty), .tx_busy(tx_busy), .in_frame(in_frame),
		.ack_slot(ack_slot), .ack_value(ack_value),
		.tx_bit(tx_bit), .fwd_bit(fwd_bit),
		.tx_start(tx_start), .pop(pop), .sink(sink),
		.tx_result(tx_result), .tx_ack(tx_ack), .DOUT(DOUT)
	);

endmodule

// File: rtl/ulpb_node_core.sv
module ulpb_node_core
	import ulpb_node_pkg::*;
	import ulpb_bus_pkg::*;
(
	input  logic            CLK,
	input  logic            RESET,
	input  logic            q_empty,
	input  logic            tx_busy,
	input  logic            in_frame,
	input  logic            ack_slot,
	input  logic            ack_value,
	input  logic            tx_bit,
	input  logic            fwd_bit,
	output logic            tx_start,
	output logic            pop,
	output logic            sink,
	output ulpb_tx_result_t tx_result,
	input  logic            tx_ack,
	output logic            DOUT
);

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_SENDING,
		ST_AWAIT_RETURN
	} core_state_e;

	core_state_e state;
	logic        bus_idle;
	logic        result_pending;

	assign bus_idle       = !in_frame && !tx_busy;
	assign result_pending = tx_result.success || tx_result.fail;

	// own frame while sending and forwarded traffic otherwise.
	assign DOUT = tx_busy ? tx_bit : fwd_bit;

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state     <= ST_IDLE;
			tx_start  <= 1'b0;
			pop       <= 1'b0;
			sink      <= 1'b0;
			tx_result <= '0;
		end
		else
		begin
			tx_start <= 1'b0;
			pop      <= 1'b0;

			if (tx_ack && result_pending)
				tx_result <= '0;

			case (state)
				ST_IDLE:
				begin
					if (!q_empty && bus_idle && !result_pending)
					begin
						tx_start <= 1'b1;
						sink     <= 1'b1;
						state    <= ST_SENDING;
					end
				end
				ST_SENDING, ST_AWAIT_RETURN:
				begin
					// short rings can return the ack before SENDING ends.
					if (ack_slot)
					begin
						tx_result.success <= (ack_value == ACK_TAKEN);
						tx_result.fail    <= (ack_value != ACK_TAKEN);
						pop               <= 1'b1;
						sink              <= 1'b0;
						state             <= ST_IDLE;
					end
					else if (state == ST_SENDING && !tx_start && !tx_busy)
						state <= ST_AWAIT_RETURN;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/ulpb_rx_framer.sv
module ulpb_rx_framer
	import ulpb_node_pkg::*;
	import ulpb_bus_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS      = 8'hab,
	parameter logic [ADDR_WIDTH-1:0] ADDRESS_MASK = 8'hff
)
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      DIN,
	input  logic      sink,
	output logic      fwd_bit,
	output logic      in_frame,
	output logic      ack_slot,
	output logic      ack_value,
	output ulpb_msg_t lc_rx_msg,
	output logic      lc_rx_req,
	input  logic      lc_rx_ack
);

	localparam int MAX_FIELD = (DATA_WIDTH > ADDR_WIDTH) ? DATA_WIDTH : ADDR_WIDTH;
	localparam int CNT_W     = $clog2(MAX_FIELD);

	ulpb_phase_e           phase; // part of the frame now on DIN.
	logic [CNT_W-1:0]      cnt;
	logic [MSG_WIDTH-1:0]  sreg;
	logic [ADDR_WIDTH-1:0] rx_addr;
	logic                  match;
	logic                  take;

	// a start bit on an idle line already counts as frame traffic.
	assign in_frame  = (phase != IDLE) || (DIN == START_LEVEL);
	assign ack_slot  = (phase == ACK);
	assign ack_value = DIN;

	assign rx_addr = sreg[MSG_WIDTH-1 -: ADDR_WIDTH];
	assign match   = ((rx_addr & ADDRESS_MASK) == (ADDRESS & ADDRESS_MASK));
	// LC output must be free, and own frames are never taken.
	assign take    = ack_slot && match && !sink && !lc_rx_req && !lc_rx_ack;

	// ********************
	// frame tracking
	// ********************

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (phase)
				IDLE:
				begin
					if (DIN == START_LEVEL)
					begin
						phase <= ADDR;
						cnt   <= '0;
					end
				end
				ADDR:
				begin
					if (cnt == CNT_W'(ADDR_WIDTH - 1))
					begin
						phase <= DATA;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				DATA:
				begin
					if (cnt == CNT_W'(DATA_WIDTH - 1))
						phase <= ACK;
					else
						cnt <= cnt + 1'b1;
				end
				default: phase <= IDLE; // ack slot done.
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (phase == ADDR || phase == DATA)
			sreg <= {sreg[MSG_WIDTH-2:0], DIN};
	end

	// ********************
	// forward path and LC side
	// ********************

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			fwd_bit   <= IDLE_LEVEL;
			lc_rx_req <= 1'b0;
		end
		else
		begin
			if (sink)
				fwd_bit <= IDLE_LEVEL; // own frame ends here.
			else if (take)
				fwd_bit <= ACK_TAKEN;
			else
				fwd_bit <= DIN;

			if (take)
				lc_rx_req <= 1'b1;
			else if (lc_rx_ack)
				lc_rx_req <= 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (take)
			lc_rx_msg <= sreg;
	end

endmodule

// File: rtl/ulpb_tx_framer.sv
module ulpb_tx_framer
	import ulpb_node_pkg::*;
	import ulpb_bus_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      tx_start,
	input  ulpb_msg_t head_msg,
	output logic      tx_bit,
	output logic      tx_busy
);

	localparam int MAX_FIELD = (DATA_WIDTH > ADDR_WIDTH) ? DATA_WIDTH : ADDR_WIDTH;
	localparam int CNT_W     = $clog2(MAX_FIELD);

	ulpb_phase_e          phase; // part of the frame now on tx_bit.
	logic [CNT_W-1:0]     cnt;
	logic [MSG_WIDTH-1:0] sreg;

	assign tx_busy = (phase != IDLE);

	// ********************
	// bit sequencing
	// ********************

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase  <= IDLE;
			cnt    <= '0;
			tx_bit <= IDLE_LEVEL;
		end
		else
		begin
			case (phase)
				IDLE:
				begin
					tx_bit <= IDLE_LEVEL;
					if (tx_start)
					begin
						phase  <= START;
						tx_bit <= START_LEVEL;
					end
				end
				START:
				begin
					phase  <= ADDR;
					cnt    <= '0;
					tx_bit <= sreg[MSG_WIDTH-1]; // address msb.
				end
				ADDR:
				begin
					tx_bit <= sreg[MSG_WIDTH-1];
					if (cnt == CNT_W'(ADDR_WIDTH - 1))
					begin
						phase <= DATA;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				DATA:
				begin
					if (cnt == CNT_W'(DATA_WIDTH - 1))
					begin
						phase  <= ACK;
						tx_bit <= ~ACK_TAKEN; // sent as 1.
					end
					else
					begin
						cnt    <= cnt + 1'b1;
						tx_bit <= sreg[MSG_WIDTH-1];
					end
				end
				ACK:
				begin
					phase  <= IDLE;
					tx_bit <= IDLE_LEVEL;
				end
				default: phase <= IDLE;
			endcase
		end
	end

	// address and data are contiguous, so one shift covers both.
	always_ff @(posedge CLK)
	begin
		if (phase == IDLE && tx_start)
			sreg <= head_msg;
		else if (phase == START || phase == ADDR || phase == DATA)
			sreg <= {sreg[MSG_WIDTH-2:0], 1'b0};
	end

endmodule

// File: rtl/ulpb_tx_queue.sv
module ulpb_tx_queue
	import ulpb_node_pkg::*;
#(
	parameter int QUEUE_DEPTH = 8
)
(
	input  logic      CLK,
	input  logic      RESET,
	input  ulpb_msg_t lc_tx_msg,
	input  logic      lc_tx_req,
	output logic      lc_tx_ack,
	input  logic      pop,
	output ulpb_msg_t head_msg,
	output logic      q_empty
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	ulpb_msg_t        mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] head;  // write side.
	logic [PTR_W-1:0] tail;  // read side.
	logic [CNT_W-1:0] count;
	logic             full;
	logic             push;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign full     = (count == CNT_W'(QUEUE_DEPTH));
	assign q_empty  = (count == '0);
	assign push     = lc_tx_req && !lc_tx_ack && !full; // full keeps ack low.
	assign head_msg = mem[tail];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			lc_tx_ack <= 1'b0;
		end
		else
		begin
			if (push)
				head <= next_ptr(head);
			if (pop)
				tail <= next_ptr(tail);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			if (push)
				lc_tx_ack <= 1'b1;
			else if (!lc_tx_req)
				lc_tx_ack <= 1'b0; // second half of the four-phase cycle.
		end
	end

	always_ff @(posedge CLK)
	begin
		if (push)
			mem[head] <= lc_tx_msg;
	end

endmodule

// File: rtl/ulpb_bus_pkg.sv
package ulpb_bus_pkg;

	import ulpb_node_pkg::*;

	// ********************
	// line format
	// ********************

	// start bit, address, data, acknowledge bit.
	localparam int FRAME_BITS = 1 + ADDR_WIDTH + DATA_WIDTH + 1;

	localparam logic IDLE_LEVEL  = 1'b1; // line level between frames.
	localparam logic START_LEVEL = 1'b0;
	localparam logic ACK_TAKEN   = 1'b0; // written by the addressed node.

	// ********************
	// framer phases
	// ********************

	typedef enum logic [2:0]
	{
		IDLE,
		START,
		ADDR,
		DATA,
		ACK
	} ulpb_phase_e;

endpackage

// File: rtl/ulpb_node_pkg.sv
package ulpb_node_pkg;

	// ********************
	// message geometry
	// ********************

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int MSG_WIDTH  = ADDR_WIDTH + DATA_WIDTH; // serialized payload.

	// ********************
	// shared records
	// ********************

	// one address/data message with addr in the upper bits.
	typedef struct packed
	{
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} ulpb_msg_t;

	// outcome of the last own frame.
	typedef struct packed
	{
		logic success; // remote node took it.
		logic fail;    // acknowledge bit came back at 1.
	} ulpb_tx_result_t;

endpackage
